//--- logic/csr_pkg.sv
package csr_pkg;

    // ========================================================================
    // Widths
    // ========================================================================
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Hardware counters are two machine words wide
    localparam int CNT_W = 2 * XLEN;

    // ========================================================================
    // CSR addresses kept in this unit
    // ========================================================================
    typedef enum logic [CSR_ADDR_W-1:0] {
        // Custom scratch
        SCRATCH  = 12'h800,
        // Machine trap setup and handling
        MSTATUS  = 12'h300,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MTVAL    = 12'h343,
        // User read-only counters, low and high halves
        CYCLE    = 12'hC00,
        CYCLEH   = 12'hC80,
        INSTRET  = 12'hC02,
        INSTRETH = 12'hC82
    } csr_addr_e;

    // Access operation, as decoded from the CSR instruction
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    // ========================================================================
    // Port structs
    // ========================================================================
    typedef struct packed {
        logic                  wren;
        logic                  rden;
        csr_op_e               op;
        // Raw address, may hold unmapped values
        logic [CSR_ADDR_W-1:0] addr;
        logic                  imm_sel;
        logic [XLEN-1:0]       imm;
    } csr_inst_t;

    typedef struct packed {
        logic illegal_instruction;
        logic misaligned_access;
        logic illegal_csr_access;
        logic breakpoint;
        logic retire_valid;
    } hw_event_t;

    typedef struct packed {
        logic [CNT_W-1:0] cycle;
        logic [CNT_W-1:0] instret;
    } counter_state_t;

    typedef struct packed {
        logic [XLEN-1:0] scratch;
        logic [XLEN-1:0] mstatus;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
    } machine_state_t;

    // ========================================================================
    // Trap causes and handler vectors
    // ========================================================================
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INST = 32'h0000_0002;
    localparam logic [XLEN-1:0] CAUSE_MISALIGNED   = 32'h0000_0004;
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_CSR  = 32'h0000_000B;
    localparam logic [XLEN-1:0] CAUSE_BREAKPOINT   = 32'h0000_0003;

    localparam logic [XLEN-1:0] VEC_ILLEGAL_INST = 32'h0000_0100;
    localparam logic [XLEN-1:0] VEC_MISALIGNED   = 32'h0000_0200;
    localparam logic [XLEN-1:0] VEC_ILLEGAL_CSR  = 32'h0000_0300;
    localparam logic [XLEN-1:0] VEC_BREAKPOINT   = 32'h0000_0400;

endpackage

//--- logic/csr_counters.sv
`timescale 1ns/100ps

module csr_counters (
    input  logic                    clk,
    input  logic                    rst_n,
    input  csr_pkg::hw_event_t      events,
    output csr_pkg::counter_state_t counters
);

    import csr_pkg::*;

    // ========================================================================
    // Next counter values
    // ========================================================================
    // Each counter is kept as two words so the carry into the high
    // half is explicit, matching the CYCLEH / INSTRETH view

    logic [XLEN-1:0] cycle_lo_next;
    logic [XLEN-1:0] cycle_hi_next;
    logic            cycle_carry;

    logic [XLEN-1:0] instret_lo_next;
    logic [XLEN-1:0] instret_hi_next;
    logic            instret_carry;

    always_comb begin
        // Free running, one step per clock
        {cycle_carry, cycle_lo_next} = {1'b0, counters.cycle[XLEN-1:0]} + 1'b1;
        cycle_hi_next = counters.cycle[CNT_W-1:XLEN] + cycle_carry;
    end

    always_comb begin
        // Step only on a retired instruction
        {instret_carry, instret_lo_next} =
            {1'b0, counters.instret[XLEN-1:0]} + events.retire_valid;
        instret_hi_next = counters.instret[CNT_W-1:XLEN] + instret_carry;
    end

    // ========================================================================
    // Counter registers
    // ========================================================================
    // Read-only to software, so no write path reaches them

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            counters <= '0;
        end else begin
            counters.cycle   <= {cycle_hi_next, cycle_lo_next};
            counters.instret <= {instret_hi_next, instret_lo_next};
        end
    end

endmodule

//--- logic/csr_machine_regs.sv
`timescale 1ns/100ps

module csr_machine_regs #(
    parameter logic [csr_pkg::XLEN-1:0] SCRATCH_RESET = 32'h0000_1001
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  csr_pkg::csr_inst_t          inst,
    input  logic [csr_pkg::XLEN-1:0]    write_data,
    input  logic [csr_pkg::XLEN-1:0]    pc,
    input  csr_pkg::hw_event_t          events,
    output csr_pkg::machine_state_t     machine
);

    import csr_pkg::*;

    // One register update for write, set or clear
    function automatic logic [XLEN-1:0] apply_op(
        input logic [XLEN-1:0] old_val,
        input logic [XLEN-1:0] data,
        input csr_op_e         op
    );
        logic [XLEN-1:0] result;
        case (op)
            CSR_WRITE: result = data;
            CSR_SET:   result = old_val | data;
            CSR_CLEAR: result = old_val & ~data;
            default:   result = old_val;
        endcase
        return result;
    endfunction

    machine_state_t  machine_next;
    logic [XLEN-1:0] operand;

    logic            trap_valid;
    logic [XLEN-1:0] trap_cause;
    logic [XLEN-1:0] trap_vec;

    // Operand is the zero-extended immediate or the rs1 value
    assign operand = inst.imm_sel ? inst.imm : write_data;

    // ========================================================================
    // Exception select
    // ========================================================================
    // Breakpoint first, illegal instruction last
    always_comb begin
        trap_valid = 1'b1;
        trap_cause = '0;
        trap_vec   = '0;
        if (events.breakpoint) begin
            trap_cause = CAUSE_BREAKPOINT;
            trap_vec   = VEC_BREAKPOINT;
        end else if (events.illegal_csr_access) begin
            trap_cause = CAUSE_ILLEGAL_CSR;
            trap_vec   = VEC_ILLEGAL_CSR;
        end else if (events.misaligned_access) begin
            trap_cause = CAUSE_MISALIGNED;
            trap_vec   = VEC_MISALIGNED;
        end else if (events.illegal_instruction) begin
            trap_cause = CAUSE_ILLEGAL_INST;
            trap_vec   = VEC_ILLEGAL_INST;
        end else begin
            trap_valid = 1'b0;
        end
    end

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        machine_next = machine;

        // Software access, at most one register per cycle
        if (inst.wren) begin
            case (inst.addr)
                SCRATCH: begin
                    machine_next.scratch = apply_op(machine.scratch, operand, inst.op);
                end
                MSTATUS: begin
                    machine_next.mstatus = apply_op(machine.mstatus, operand, inst.op);
                end
                MIE: begin
                    machine_next.mie = apply_op(machine.mie, operand, inst.op);
                end
                MTVEC: begin
                    machine_next.mtvec = apply_op(machine.mtvec, operand, inst.op);
                end
                MSCRATCH: begin
                    machine_next.mscratch = apply_op(machine.mscratch, operand, inst.op);
                end
                MEPC: begin
                    machine_next.mepc = apply_op(machine.mepc, operand, inst.op);
                end
                MCAUSE: begin
                    machine_next.mcause = apply_op(machine.mcause, operand, inst.op);
                end
                MTVAL: begin
                    machine_next.mtval = apply_op(machine.mtval, operand, inst.op);
                end
                // Counters and unmapped addresses ignore writes
                default: begin
                    machine_next = machine;
                end
            endcase
        end

        // Hardware trap capture overrides the software write
        if (trap_valid) begin
            machine_next.mcause = trap_cause;
            machine_next.mtvec  = trap_vec;
            machine_next.mepc   = pc;
        end
    end

    // ========================================================================
    // Registers
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            machine         <= '0;
            machine.scratch <= SCRATCH_RESET;
        end else begin
            machine <= machine_next;
        end
    end

endmodule

//--- logic/csr_read_mux.sv
`timescale 1ns/100ps

module csr_read_mux (
    input  csr_pkg::csr_inst_t          inst,
    input  csr_pkg::counter_state_t     counters,
    input  csr_pkg::machine_state_t     machine,
    output logic [csr_pkg::XLEN-1:0]    read_data
);

    import csr_pkg::*;

    // ========================================================================
    // Read decode
    // ========================================================================
    // Purely combinational, so a read sees the value from before any
    // write issued in the same cycle

    always_comb begin
        read_data = '0;
        if (inst.rden) begin
            case (inst.addr)
                // Counter halves
                CYCLE: begin
                    read_data = counters.cycle[XLEN-1:0];
                end
                CYCLEH: begin
                    read_data = counters.cycle[CNT_W-1:XLEN];
                end
                INSTRET: begin
                    read_data = counters.instret[XLEN-1:0];
                end
                INSTRETH: begin
                    read_data = counters.instret[CNT_W-1:XLEN];
                end

                // Machine registers
                SCRATCH: begin
                    read_data = machine.scratch;
                end
                MSTATUS: begin
                    read_data = machine.mstatus;
                end
                MIE: begin
                    read_data = machine.mie;
                end
                MTVEC: begin
                    read_data = machine.mtvec;
                end
                MSCRATCH: begin
                    read_data = machine.mscratch;
                end
                MEPC: begin
                    read_data = machine.mepc;
                end
                MCAUSE: begin
                    read_data = machine.mcause;
                end
                MTVAL: begin
                    read_data = machine.mtval;
                end

                // Unmapped, including the constant ID registers
                default: begin
                    read_data = '0;
                end
            endcase
        end
    end

endmodule

//--- logic/csr_unit.sv
`timescale 1ns/100ps

module csr_unit #(
    parameter logic [csr_pkg::XLEN-1:0] SCRATCH_RESET = 32'h0000_1001
) (
    input  logic                        clk,
    input  logic                        rst_n,
    // Access from the pipeline, one per cycle
    input  csr_pkg::csr_inst_t          inst,
    input  logic [csr_pkg::XLEN-1:0]    write_data,
    input  logic [csr_pkg::XLEN-1:0]    pc,
    // Hardware exceptions and retire strobe
    input  csr_pkg::hw_event_t          events,
    output logic [csr_pkg::XLEN-1:0]    read_data
);

    import csr_pkg::*;

    counter_state_t counters;
    machine_state_t machine;

    // ========================================================================
    // Register blocks
    // ========================================================================

    // Read-only hardware counters
    csr_counters u_counters (
        .clk      (clk),
        .rst_n    (rst_n),
        .events   (events),
        .counters (counters)
    );

    // Software-writable machine registers with trap capture
    csr_machine_regs #(
        .SCRATCH_RESET (SCRATCH_RESET)
    ) u_machine_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .write_data (write_data),
        .pc         (pc),
        .events     (events),
        .machine    (machine)
    );

    // ========================================================================
    // Read path
    // ========================================================================
    csr_read_mux u_read_mux (
        .inst      (inst),
        .counters  (counters),
        .machine   (machine),
        .read_data (read_data)
    );

endmodule

//--- bench/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// ============================================================================
// Reference state
// ============================================================================
// Writable registers kept in address table order, scratch in slot 0
typedef struct packed {
    logic [7:0][31:0] regs;
    logic [63:0]      cycle;
    logic [63:0]      instret;
} ref_state_t;

localparam int SLOT_MTVEC  = 3;
localparam int SLOT_MEPC   = 5;
localparam int SLOT_MCAUSE = 6;

// Slot of a writable register, -1 when the address has none
function automatic int csr_slot(input logic [11:0] addr);
    case (addr)
        12'h800: return 0;
        12'h300: return 1;
        12'h304: return 2;
        12'h305: return 3;
        12'h340: return 4;
        12'h341: return 5;
        12'h342: return 6;
        12'h343: return 7;
        default: return -1;
    endcase
endfunction

function automatic ref_state_t model_reset(input logic [31:0] scratch_init);
    ref_state_t s;
    s         = '0;
    s.regs[0] = scratch_init;
    return s;
endfunction

function automatic logic [31:0] model_read(input ref_state_t s, input csr_inst_t acc);
    int slot;
    slot = csr_slot(acc.addr);
    if (!acc.rden) begin
        return 32'd0;
    end
    if (slot >= 0) begin
        return s.regs[slot];
    end
    case (acc.addr)
        12'hC00: return s.cycle[31:0];
        12'hC80: return s.cycle[63:32];
        12'hC02: return s.instret[31:0];
        12'hC82: return s.instret[63:32];
        default: return 32'd0;
    endcase
endfunction

function automatic ref_state_t model_next(
    input ref_state_t  s,
    input csr_inst_t   acc,
    input logic [31:0] rs1,
    input logic [31:0] pc_val,
    input hw_event_t   ev
);
    ref_state_t  n;
    logic [31:0] data;
    int          slot;
    n    = s;
    data = acc.imm_sel ? acc.imm : rs1;
    slot = csr_slot(acc.addr);
    if (acc.wren && slot >= 0) begin
        case (acc.op)
            CSR_WRITE: n.regs[slot] = data;
            CSR_SET:   n.regs[slot] = s.regs[slot] | data;
            CSR_CLEAR: n.regs[slot] = s.regs[slot] & ~data;
            default:   n.regs[slot] = s.regs[slot];
        endcase
    end
    // Trap wins over software, breakpoint first
    if (ev.breakpoint) begin
        n.regs[SLOT_MCAUSE] = 32'd3;
        n.regs[SLOT_MTVEC]  = 32'h400;
    end else if (ev.illegal_csr_access) begin
        n.regs[SLOT_MCAUSE] = 32'd11;
        n.regs[SLOT_MTVEC]  = 32'h300;
    end else if (ev.misaligned_access) begin
        n.regs[SLOT_MCAUSE] = 32'd4;
        n.regs[SLOT_MTVEC]  = 32'h200;
    end else if (ev.illegal_instruction) begin
        n.regs[SLOT_MCAUSE] = 32'd2;
        n.regs[SLOT_MTVEC]  = 32'h100;
    end
    if (ev.breakpoint | ev.illegal_csr_access | ev.misaligned_access | ev.illegal_instruction) begin
        n.regs[SLOT_MEPC] = pc_val;
    end
    n.cycle   = s.cycle + 64'd1;
    n.instret = s.instret + {63'd0, ev.retire_valid};
    return n;
endfunction

// One Galois step, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

`endif

//--- bench/csr_tb.sv
`timescale 1ns/100ps

module csr_tb;

    import csr_pkg::*;

    `include "csr_model.svh"

    localparam int          CLK_PERIOD      = 40;
    localparam int          RESET_CYCLES    = 10;
    // Directed phases take about 250 cycles
    localparam int          DIRECTED_CYCLES = 300;
    localparam int          RANDOM_CYCLES   = 2000;
    localparam int          TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD * 2;
    localparam logic [31:0] SCRATCH_RESET   = 32'h0000_1001;

    localparam logic [11:0] MACHINE_ADDRS [8] = '{
        SCRATCH, MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL
    };
    localparam logic [11:0] ALL_ADDRS [12] = '{
        SCRATCH, MSTATUS, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL,
        CYCLE, CYCLEH, INSTRET, INSTRETH
    };

    logic        clk;
    logic        rst_n;
    csr_inst_t   inst;
    logic [31:0] write_data;
    logic [31:0] pc;
    hw_event_t   events;
    logic [31:0] read_data;

    ref_state_t  model;
    logic        model_valid = 1'b0;
    logic [31:0] lfsr        = 32'h8bf39e45;

    csr_unit #(
        .SCRATCH_RESET (SCRATCH_RESET)
    ) u_csr_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .write_data (write_data),
        .pc         (pc),
        .events     (events),
        .read_data  (read_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================================================
    // Reference model and compare
    // ========================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            model       <= model_reset(SCRATCH_RESET);
            model_valid <= 1'b1;
        end else if (model_valid) begin
            model <= model_next(model, inst, write_data, pc, events);
        end
    end

    // Sample 1 ns before the next rising edge
    initial begin
        forever begin
            @(posedge clk);
            #(CLK_PERIOD - 1);
            if (model_valid) begin
                check_value("read_data", model_read(model, inst), read_data);
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the test did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic check_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], take_bit()};
        end
        return v;
    endfunction

    // Entered 2 ns after an edge, returns 2 ns after the next one
    task automatic end_cycle(output logic [31:0] rdata);
        #(CLK_PERIOD - 3);
        rdata = read_data;
        @(posedge clk);
        #2;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] rdata);
        inst      = '0;
        inst.rden = 1'b1;
        inst.addr = addr;
        events    = '0;
        end_cycle(rdata);
    endtask

    // Operand not selected carries noise
    task automatic drive_write(
        input logic [11:0] addr,
        input csr_op_e     op,
        input logic        imm_sel,
        input logic [31:0] value
    );
        logic [31:0] noise;
        noise        = take_bits(32);
        inst         = '0;
        inst.wren    = 1'b1;
        inst.op      = op;
        inst.addr    = addr;
        inst.imm_sel = imm_sel;
        events       = '0;
        if (imm_sel) begin
            inst.imm   = value;
            write_data = noise;
        end else begin
            inst.imm   = {27'd0, noise[4:0]};
            write_data = value;
        end
    endtask

    task automatic write_csr(
        input logic [11:0] addr,
        input csr_op_e     op,
        input logic        imm_sel,
        input logic [31:0] value
    );
        logic [31:0] rd;
        drive_write(addr, op, imm_sel, value);
        end_cycle(rd);
    endtask

    task automatic raise_exception(
        input hw_event_t   ev,
        input logic [31:0] cause,
        input logic [31:0] vec
    );
        logic [31:0] rd;
        logic [31:0] epc;
        epc    = take_bits(32);
        inst   = '0;
        events = ev;
        pc     = epc;
        end_cycle(rd);
        read_csr(MCAUSE, rd);
        check_value("mcause", cause, rd);
        read_csr(MTVEC, rd);
        check_value("mtvec", vec, rd);
        read_csr(MEPC, rd);
        check_value("mepc", epc, rd);
    endtask

    // ========================================================================
    // Test phases
    // ========================================================================
    task automatic reset_phase();
        logic [31:0] rd;
        read_csr(SCRATCH, rd);
        check_value("scratch", SCRATCH_RESET, rd);
        for (int i = 1; i < 8; i++) begin
            read_csr(MACHINE_ADDRS[i], rd);
            check_value("machine register after reset", 32'd0, rd);
        end
    endtask

    task automatic write_phase();
        logic [31:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic        imm_sel;
        for (int s = 0; s < 2; s++) begin
            imm_sel = (s == 1);
            for (int i = 0; i < 8; i++) begin
                a = imm_sel ? take_bits(5) : take_bits(32);
                b = imm_sel ? take_bits(5) : take_bits(32);
                c = imm_sel ? take_bits(5) : take_bits(32);
                write_csr(MACHINE_ADDRS[i], CSR_WRITE, imm_sel, a);
                read_csr(MACHINE_ADDRS[i], rd);
                check_value("read_data after write", a, rd);
                write_csr(MACHINE_ADDRS[i], CSR_SET, imm_sel, b);
                read_csr(MACHINE_ADDRS[i], rd);
                check_value("read_data after set", a | b, rd);
                write_csr(MACHINE_ADDRS[i], CSR_CLEAR, imm_sel, c);
                read_csr(MACHINE_ADDRS[i], rd);
                check_value("read_data after clear", (a | b) & ~c, rd);
                write_csr(MACHINE_ADDRS[i], CSR_NONE, imm_sel, a);
                read_csr(MACHINE_ADDRS[i], rd);
                check_value("read_data after no-op", (a | b) & ~c, rd);
            end
        end
    endtask

    task automatic counter_phase();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] rd;
        int          retires;
        read_csr(CYCLE, first);
        repeat (24) read_csr(MSTATUS, rd);
        read_csr(CYCLE, second);
        check_value("cycle delta", 32'd25, second - first);

        retires = 0;
        read_csr(INSTRET, first);
        for (int i = 0; i < 40; i++) begin
            inst                = '0;
            events              = '0;
            events.retire_valid = take_bit();
            if (events.retire_valid) begin
                retires++;
            end
            end_cycle(rd);
        end
        read_csr(INSTRET, second);
        check_value("instret delta", retires, second - first);
        read_csr(INSTRETH, rd);
        check_value("instreth", 32'd0, rd);

        // Counter writes are ignored
        read_csr(CYCLE, first);
        write_csr(CYCLE, CSR_WRITE, 1'b0, 32'd0);
        read_csr(CYCLE, second);
        check_value("cycle after write", first + 32'd2, second);
        read_csr(INSTRET, first);
        write_csr(INSTRET, CSR_CLEAR, 1'b0, 32'hFFFF_FFFF);
        write_csr(INSTRETH, CSR_SET, 1'b0, 32'hFFFF_FFFF);
        read_csr(INSTRET, second);
        check_value("instret after write", first, second);
        write_csr(CYCLEH, CSR_SET, 1'b0, 32'hFFFF_FFFF);
        read_csr(CYCLEH, rd);
        check_value("cycleh after write", 32'd0, rd);
    endtask

    task automatic exception_phase();
        hw_event_t   ev;
        logic [31:0] rd;
        ev = '0;
        ev.illegal_instruction = 1'b1;
        raise_exception(ev, 32'd2, 32'h100);
        ev = '0;
        ev.misaligned_access = 1'b1;
        raise_exception(ev, 32'd4, 32'h200);
        ev = '0;
        ev.illegal_csr_access = 1'b1;
        raise_exception(ev, 32'd11, 32'h300);
        ev = '0;
        ev.breakpoint = 1'b1;
        raise_exception(ev, 32'd3, 32'h400);

        // Several at once
        ev = '1;
        ev.retire_valid = 1'b0;
        raise_exception(ev, 32'd3, 32'h400);
        ev.breakpoint = 1'b0;
        raise_exception(ev, 32'd11, 32'h300);
        ev.illegal_csr_access = 1'b0;
        raise_exception(ev, 32'd4, 32'h200);

        // Trap and software write to mcause in one cycle
        drive_write(MCAUSE, CSR_WRITE, 1'b0, 32'hDEAD_BEEF);
        events.illegal_instruction = 1'b1;
        pc = take_bits(32);
        end_cycle(rd);
        read_csr(MCAUSE, rd);
        check_value("mcause with write", 32'd2, rd);
    endtask

    task automatic zero_read_phase();
        logic [31:0] rd;
        inst      = '0;
        inst.addr = SCRATCH;
        events    = '0;
        end_cycle(rd);
        check_value("read_data with rden low", 32'd0, rd);
        read_csr(12'h000, rd);
        check_value("unmapped read", 32'd0, rd);
        read_csr(12'hF11, rd);
        check_value("unmapped read", 32'd0, rd);
        read_csr(12'h301, rd);
        check_value("unmapped read", 32'd0, rd);
        read_csr(12'hC01, rd);
        check_value("unmapped read", 32'd0, rd);
        read_csr(12'hB00, rd);
        check_value("unmapped read", 32'd0, rd);
    endtask

    // Compare process checks each of these cycles
    task automatic random_phase();
        logic [31:0] r;
        int          k;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            inst.wren = take_bit();
            inst.rden = take_bit();
            r         = take_bits(2);
            inst.op   = csr_op_e'(r[1:0]);
            r         = take_bits(5);
            if (r < 32'd26) begin
                k         = int'(take_bits(4)) % 12;
                inst.addr = ALL_ADDRS[k];
            end else begin
                r         = take_bits(12);
                inst.addr = r[11:0];
            end
            inst.imm_sel               = take_bit();
            inst.imm                   = take_bits(5);
            write_data                 = take_bits(32);
            pc                         = take_bits(32);
            events.illegal_instruction = (take_bits(4) == 32'd0);
            events.misaligned_access   = (take_bits(4) == 32'd0);
            events.illegal_csr_access  = (take_bits(4) == 32'd0);
            events.breakpoint          = (take_bits(4) == 32'd0);
            events.retire_valid        = take_bit();
            end_cycle(r);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        rst_n      = 1'b0;
        inst       = '0;
        write_data = '0;
        pc         = '0;
        events     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
        reset_phase();
        write_phase();
        counter_phase();
        exception_phase();
        zero_read_phase();
        random_phase();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- list.f
logic/csr_pkg.sv
logic/csr_counters.sv
logic/csr_machine_regs.sv
logic/csr_read_mux.sv
logic/csr_unit.sv
bench/csr_tb.sv
+incdir+bench

//--- Makefile
TOP = csr_tb

sim:
	verilator --binary -Wno-fatal --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
